/* Makefile */
BPRED     ?= 1
TOP       ?= fetch_tb
OUT_DIR   ?= build
SEED      ?= 51325
VERILATOR ?= verilator

FILELIST := all.f
SRCS     := $(shell grep -v '^+' $(FILELIST))
MDIR     := $(OUT_DIR)/bpred$(BPRED)
BIN      := $(MDIR)/V$(TOP)
LOG      := $(MDIR)/sim.log
PASS_MSG := *** TEST PASSED ***

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --assert --timing -f $(FILELIST) --top-module $(TOP) \
	  -GBPRED=$(BPRED) -Mdir $(MDIR) -o V$(TOP)

run: $(BIN)
	$(BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OUT_DIR)

/* all.f */
src/fetch_pkg.sv
src/fetch_pred_if.sv
src/btb.sv
src/ras.sv
src/pc_gen.sv
src/if_stage_bram.sv
src/imem_bram.sv
src/fetch_top.sv
tb/fetch_tb.sv

/* src/btb.sv */
`timescale 1ns/10ps

module btb (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [fetch_pkg::XLEN-1:0] lookup_pc,
  input  logic                       upd_valid,
  input  logic [fetch_pkg::XLEN-1:0] upd_pc,
  input  logic [fetch_pkg::XLEN-1:0] upd_target,
  input  logic                       upd_taken,
  input  logic                       upd_is_call,
  input  logic                       upd_is_return,
  fetch_pred_if.btb_src              pred,
  output logic                       hit_is_call
);
  import fetch_pkg::*;

  // Per-entry state, only the valid bits need a known value after reset
  logic                 entry_valid  [BTB_ENTRIES];
  logic [BTB_TAG_W-1:0] entry_tag    [BTB_ENTRIES];
  logic [XLEN-1:0]      entry_target [BTB_ENTRIES];
  logic                 entry_taken  [BTB_ENTRIES];
  logic                 entry_call   [BTB_ENTRIES];
  logic                 entry_return [BTB_ENTRIES];

  logic [BTB_IDX_W-1:0] lookup_idx;
  logic [BTB_TAG_W-1:0] lookup_tag;
  logic [BTB_IDX_W-1:0] upd_idx;
  logic [BTB_TAG_W-1:0] upd_tag;
  logic                 lookup_hit;

  // Word-aligned PCs, so bits [1:0] never take part in index or tag
  assign lookup_idx = lookup_pc[BTB_IDX_W+1:2];
  assign lookup_tag = lookup_pc[XLEN-1:BTB_IDX_W+2];
  assign upd_idx    = upd_pc[BTB_IDX_W+1:2];
  assign upd_tag    = upd_pc[XLEN-1:BTB_IDX_W+2];

  // An update marks its entry as live until the next reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        entry_valid[i] <= 1'b0;
      end
    end else if (upd_valid) begin
      entry_valid[upd_idx] <= 1'b1;
    end
  end

  // A later update to the same index simply replaces the old branch
  always_ff @(posedge clk) begin
    if (upd_valid) begin
      entry_tag[upd_idx]    <= upd_tag;
      entry_target[upd_idx] <= upd_target;
      entry_taken[upd_idx]  <= upd_taken;
      entry_call[upd_idx]   <= upd_is_call;
      entry_return[upd_idx] <= upd_is_return;
    end
  end

  // Lookup is purely combinational so pc_gen can use it in the same cycle
  assign lookup_hit = entry_valid[lookup_idx] && (entry_tag[lookup_idx] == lookup_tag);

  // All flags are qualified by the hit so a stale entry never leaks out
  assign pred.hit       = lookup_hit;
  assign pred.taken     = lookup_hit && entry_taken[lookup_idx];
  assign pred.target    = entry_target[lookup_idx];
  assign pred.is_return = lookup_hit && entry_return[lookup_idx];
  assign hit_is_call    = lookup_hit && entry_call[lookup_idx];

endmodule

/* src/fetch_pkg.sv */
package fetch_pkg;

  // Width of every address, PC and branch target in the front end
  localparam int XLEN = 32;

  // The first instruction handed to decode after reset sits here
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // Canonical NOP (addi x0, x0, 0) that replaces squashed fetch slots
  localparam logic [31:0] I_NOP = 32'h0000_0013;

  // Instruction RAM size in 32-bit words
  localparam int IMEM_DEPTH = 256;

  // Word address width of the instruction RAM
  localparam int IMEM_AW = 8;

  // Direct-mapped BTB with one entry per index
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W = 4;

  // The BTB tag keeps every PC bit above the index and the byte offset
  localparam int BTB_TAG_W = XLEN - BTB_IDX_W - 2;

  // Return address stack depth and its pointer width
  localparam int RAS_DEPTH = 4;
  localparam int RAS_PTR_W = 2;

endpackage

/* src/fetch_pred_if.sv */
`timescale 1ns/10ps

interface fetch_pred_if;
  import fetch_pkg::*;

  // BTB result for the PC looked up in this cycle
  logic            hit;
  logic            taken;
  logic [XLEN-1:0] target;
  logic            is_return;

  // Current top of the return address stack
  logic            ras_valid;
  logic [XLEN-1:0] ras_target;

  // The BTB fills the branch fields of the prediction
  modport btb_src(output hit, output taken, output target, output is_return);

  // The RAS fills its own fields and looks at the BTB flags to decide on a pop
  modport ras_src(output ras_valid, output ras_target, input hit, input taken,
                  input is_return);

  // Next-PC selection and the fetch stage only read the prediction
  modport sink(input hit, input taken, input target, input is_return, input ras_valid,
               input ras_target);

endinterface

/* src/fetch_top.sv */
`timescale 1ns/10ps

module fetch_top #(
  parameter int BPRED = 1
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          id_ready,
  input  logic                          redirect_valid,
  input  logic [fetch_pkg::XLEN-1:0]    redirect_pc,
  input  logic                          upd_valid,
  input  logic [fetch_pkg::XLEN-1:0]    upd_pc,
  input  logic [fetch_pkg::XLEN-1:0]    upd_target,
  input  logic                          upd_taken,
  input  logic                          upd_is_call,
  input  logic                          upd_is_return,
  input  logic                          load_en,
  input  logic [fetch_pkg::IMEM_AW-1:0] load_addr,
  input  logic [31:0]                   load_data,
  output logic                          valid_id,
  output logic [31:0]                   instr_id,
  output logic [fetch_pkg::XLEN-1:0]    pc_id,
  output logic [fetch_pkg::XLEN-1:0]    pc_plus4_id,
  output logic                          btb_hit_id,
  output logic                          btb_taken_id,
  output logic [fetch_pkg::XLEN-1:0]    btb_target_id,
  output logic                          btb_is_return_id,
  output logic                          ras_valid_id,
  output logic [fetch_pkg::XLEN-1:0]    ras_target_id
);
  import fetch_pkg::*;

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] pc_next;
  logic            imem_ren;
  logic [XLEN-1:0] imem_addr;
  logic [31:0]     imem_rdata;
  logic            hit_is_call;
  logic            ras_advance;

  // Lookup result for the current pc, shared by every block
  fetch_pred_if pred_if ();

  // The stack follows the predicted path only, a redirect abandons it
  assign ras_advance = id_ready && !redirect_valid;

  pc_gen #(
    .BPRED(BPRED)
  ) u_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .id_ready      (id_ready),
    .redirect_valid(redirect_valid),
    .redirect_pc   (redirect_pc),
    .pred          (pred_if.sink),
    .pc            (pc),
    .pc_next       (pc_next)
  );

  btb u_btb (
    .clk          (clk),
    .rst_n        (rst_n),
    .lookup_pc    (pc),
    .upd_valid    (upd_valid),
    .upd_pc       (upd_pc),
    .upd_target   (upd_target),
    .upd_taken    (upd_taken),
    .upd_is_call  (upd_is_call),
    .upd_is_return(upd_is_return),
    .pred         (pred_if.btb_src),
    .hit_is_call  (hit_is_call)
  );

  ras u_ras (
    .clk        (clk),
    .rst_n      (rst_n),
    .advance    (ras_advance),
    .pc         (pc),
    .hit_is_call(hit_is_call),
    .pred       (pred_if.ras_src)
  );

  if_stage_bram #(
    .BPRED(BPRED)
  ) u_if_stage (
    .clk             (clk),
    .rst_n           (rst_n),
    .pc              (pc),
    .pc_next         (pc_next),
    .id_ready        (id_ready),
    .flush           (redirect_valid),
    .pred            (pred_if.sink),
    .imem_rdata      (imem_rdata),
    .imem_ren        (imem_ren),
    .imem_addr       (imem_addr),
    .valid_id        (valid_id),
    .instr_id        (instr_id),
    .pc_id           (pc_id),
    .pc_plus4_id     (pc_plus4_id),
    .btb_hit_id      (btb_hit_id),
    .btb_taken_id    (btb_taken_id),
    .btb_target_id   (btb_target_id),
    .btb_is_return_id(btb_is_return_id),
    .ras_valid_id    (ras_valid_id),
    .ras_target_id   (ras_target_id)
  );

  imem_bram u_imem (
    .clk  (clk),
    .ren  (imem_ren),
    .raddr(imem_addr),
    .we   (load_en),
    .waddr(load_addr),
    .wdata(load_data),
    .rdata(imem_rdata)
  );

endmodule

/* src/if_stage_bram.sv */
`timescale 1ns/10ps

module if_stage_bram #(
  parameter int BPRED = 1
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [fetch_pkg::XLEN-1:0] pc,
  input  logic [fetch_pkg::XLEN-1:0] pc_next,
  input  logic                       id_ready,
  input  logic                       flush,
  fetch_pred_if.sink                 pred,
  input  logic [31:0]                imem_rdata,
  output logic                       imem_ren,
  output logic [fetch_pkg::XLEN-1:0] imem_addr,
  output logic                       valid_id,
  output logic [31:0]                instr_id,
  output logic [fetch_pkg::XLEN-1:0] pc_id,
  output logic [fetch_pkg::XLEN-1:0] pc_plus4_id,
  output logic                       btb_hit_id,
  output logic                       btb_taken_id,
  output logic [fetch_pkg::XLEN-1:0] btb_target_id,
  output logic                       btb_is_return_id,
  output logic                       ras_valid_id,
  output logic [fetch_pkg::XLEN-1:0] ras_target_id
);
  import fetch_pkg::*;

  // The slot is the PC and prediction that belong to the word on imem_rdata
  logic            stall;
  logic [XLEN-1:0] slot_pc;
  logic            slot_hit;
  logic            slot_taken;
  logic [XLEN-1:0] slot_target;
  logic            slot_is_return;
  logic            slot_ras_valid;
  logic [XLEN-1:0] slot_ras_target;
  logic            flush_extend;
  logic            started;

  // Same advance condition as pc_gen so RAM address and PC never drift apart
  assign stall = !id_ready && !flush;

  if (BPRED != 0) begin : g_early_fetch
    // The RAM reads pc_next at the edge pc loads it, so the word on
    // imem_rdata always belongs to the current pc and its live lookup
    assign imem_addr       = pc_next;
    assign imem_ren        = !rst_n || !stall;
    assign slot_pc         = pc;
    assign slot_hit        = pred.hit;
    assign slot_taken      = pred.taken;
    assign slot_target     = pred.target;
    assign slot_is_return  = pred.is_return;
    assign slot_ras_valid  = pred.ras_valid;
    assign slot_ras_target = pred.ras_target;

    // The redirect target is read at the redirect edge, nothing stale remains
    assign flush_extend = 1'b0;
  end else begin : g_late_fetch
    assign imem_addr = pc;
    assign imem_ren  = !stall;

    // Capture address and prediction together with the RAM read
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        slot_hit       <= 1'b0;
        slot_taken     <= 1'b0;
        slot_is_return <= 1'b0;
        slot_ras_valid <= 1'b0;
      end else if (imem_ren) begin
        slot_hit       <= pred.hit;
        slot_taken     <= pred.taken;
        slot_is_return <= pred.is_return;
        slot_ras_valid <= pred.ras_valid;
      end
    end

    always_ff @(posedge clk) begin
      if (imem_ren) begin
        slot_pc         <= imem_addr;
        slot_target     <= pred.target;
        slot_ras_target <= pred.ras_target;
      end
    end

    // The old sequential word was already read when the redirect came in.
    // Keep the extra squash pending until decode takes that slot.
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        flush_extend <= 1'b0;
      end else begin
        flush_extend <= flush || (flush_extend && !id_ready);
      end
    end
  end

  // Prediction flags toward decode
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      btb_hit_id       <= 1'b0;
      btb_taken_id     <= 1'b0;
      btb_is_return_id <= 1'b0;
      ras_valid_id     <= 1'b0;
    end else if (id_ready) begin
      btb_hit_id       <= slot_hit;
      btb_taken_id     <= slot_taken;
      btb_is_return_id <= slot_is_return;
      ras_valid_id     <= slot_ras_valid;
    end
  end

  // Payload toward decode, meaningless until valid_id rises
  always_ff @(posedge clk) begin
    if (id_ready) begin
      pc_id         <= slot_pc;
      pc_plus4_id   <= slot_pc + XLEN'(4);
      btb_target_id <= slot_target;
      ras_target_id <= slot_ras_target;
    end
  end

  // Squashed slots carry a NOP so decode never sees a wrong-path word
  always_ff @(posedge clk) begin
    if (!rst_n || flush || flush_extend) begin
      instr_id <= I_NOP;
    end else if (id_ready) begin
      instr_id <= imem_rdata;
    end
  end

  // The first accepted edge after reset only primes the RAM output
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      started  <= 1'b0;
      valid_id <= 1'b0;
    end else begin
      if (id_ready) begin
        started <= 1'b1;
      end
      if (flush || flush_extend) begin
        valid_id <= 1'b0;
      end else if (id_ready) begin
        valid_id <= started;
      end
    end
  end

endmodule

/* src/imem_bram.sv */
`timescale 1ns/10ps

module imem_bram (
  input  logic                          clk,
  input  logic                          ren,
  input  logic [fetch_pkg::XLEN-1:0]    raddr,
  input  logic                          we,
  input  logic [fetch_pkg::IMEM_AW-1:0] waddr,
  input  logic [31:0]                   wdata,
  output logic [31:0]                   rdata
);
  import fetch_pkg::*;

  logic [31:0]        mem [IMEM_DEPTH];
  logic [IMEM_AW-1:0] rword;

  // Byte address in, word index out
  assign rword = raddr[IMEM_AW+1:2];

  // Load port, used while the core is held in reset
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read, the output holds while ren is low
  always_ff @(posedge clk) begin
    if (ren) begin
      rdata <= mem[rword];
    end
  end

endmodule

/* src/pc_gen.sv */
`timescale 1ns/10ps

module pc_gen #(
  parameter int BPRED = 1
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       id_ready,
  input  logic                       redirect_valid,
  input  logic [fetch_pkg::XLEN-1:0] redirect_pc,
  fetch_pred_if.sink                 pred,
  output logic [fetch_pkg::XLEN-1:0] pc,
  output logic [fetch_pkg::XLEN-1:0] pc_next
);
  import fetch_pkg::*;

  logic [XLEN-1:0] pc_seq;
  logic            advance;
  logic            take_return;
  logic            take_branch;

  assign pc_seq = pc + XLEN'(4);

  // A redirect moves the PC even while decode holds the front end
  assign advance = id_ready || redirect_valid;

  if (BPRED != 0) begin : g_bpred
    // Returns prefer the RAS over whatever target the BTB stored
    assign take_return = pred.hit && pred.taken && pred.is_return && pred.ras_valid;
    assign take_branch = pred.hit && pred.taken;
  end else begin : g_no_bpred
    // Without prediction the PC only follows redirects and the sequential path
    assign take_return = 1'b0;
    assign take_branch = 1'b0;
  end

  // Priority is redirect, then predicted return, then predicted branch
  always_comb begin
    if (redirect_valid) begin
      pc_next = redirect_pc;
    end else if (take_return) begin
      pc_next = pred.ras_target;
    end else if (take_branch) begin
      pc_next = pred.target;
    end else begin
      pc_next = pc_seq;
    end
  end

  // With early fetch the RAM is addressed with pc_next, so pc starts one word
  // before the reset vector and pc_next points at RESET_PC while in reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= (BPRED != 0) ? RESET_PC - XLEN'(4) : RESET_PC;
    end else if (advance) begin
      pc <= pc_next;
    end
  end

endmodule

/* src/ras.sv */
`timescale 1ns/10ps

module ras (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       advance,
  input  logic [fetch_pkg::XLEN-1:0] pc,
  input  logic                       hit_is_call,
  fetch_pred_if.ras_src              pred
);
  import fetch_pkg::*;

  logic [XLEN-1:0]      stack [RAS_DEPTH];
  logic [RAS_PTR_W-1:0] top_ptr;
  logic [RAS_PTR_W-1:0] push_ptr;
  logic [RAS_PTR_W:0]   count;
  logic                 nonempty;
  logic                 push;
  logic                 pop;

  // The stack is circular, a push beyond the depth overwrites the oldest entry
  assign push_ptr = top_ptr + 1'b1;
  assign nonempty = (count != '0);

  // Only act on predictions that are actually followed by the PC
  assign push = advance && hit_is_call && pred.taken;
  assign pop  = advance && pred.hit && pred.is_return && pred.taken && nonempty;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      top_ptr <= '0;
      count   <= '0;
    end else if (push) begin
      top_ptr <= push_ptr;
      // Count saturates at the depth since older entries get overwritten
      if (count != (RAS_PTR_W + 1)'(RAS_DEPTH)) begin
        count <= count + 1'b1;
      end
    end else if (pop) begin
      top_ptr <= top_ptr - 1'b1;
      count   <= count - 1'b1;
    end
  end

  // The return address of a call is the instruction right after it
  always_ff @(posedge clk) begin
    if (push) begin
      stack[push_ptr] <= pc + XLEN'(4);
    end
  end

  assign pred.ras_valid  = nonempty;
  assign pred.ras_target = stack[top_ptr];

endmodule

/* tb/fetch_tb.sv */
`timescale 1ns/10ps

module fetch_tb #(
  parameter int BPRED = 1
);
  import fetch_pkg::*;

  logic               clk;
  logic               rst_n;
  logic               id_ready;
  logic               redirect_valid;
  logic [XLEN-1:0]    redirect_pc;
  logic               upd_valid;
  logic [XLEN-1:0]    upd_pc;
  logic [XLEN-1:0]    upd_target;
  logic               upd_taken;
  logic               upd_is_call;
  logic               upd_is_return;
  logic               load_en;
  logic [IMEM_AW-1:0] load_addr;
  logic [31:0]        load_data;
  logic               valid_id;
  logic [31:0]        instr_id;
  logic [XLEN-1:0]    pc_id;
  logic [XLEN-1:0]    pc_plus4_id;
  logic               btb_hit_id;
  logic               btb_taken_id;
  logic [XLEN-1:0]    btb_target_id;
  logic               btb_is_return_id;
  logic               ras_valid_id;
  logic [XLEN-1:0]    ras_target_id;

  // Copy of the program as written through the load port
  logic [31:0]        mirror [IMEM_DEPTH];
  int unsigned        value_errors;
  int unsigned        timeout_errors;

  fetch_top #(.BPRED(BPRED)) UUT (.*);

  always #5 clk = ~clk;

  // One clock step, stimulus changes 1 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      value_errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  // Every fetch output in one word, so a hold can be checked at once
  function automatic logic [164:0] outputs_now();
    return {valid_id, instr_id, pc_id, pc_plus4_id, btb_hit_id, btb_taken_id,
            btb_target_id, btb_is_return_id, ras_valid_id, ras_target_id};
  endfunction

  // Steps at least one edge and stops on the first valid slot
  task automatic wait_valid(input string name, input int limit);
    int n;
    n = 0;
    tick();
    while (!valid_id && n < limit) begin
      tick();
      n++;
    end
    if (!valid_id) begin
      timeout_errors++;
      $display("%s: no valid fetch slot appeared within %0d cycles", name, limit);
    end
  endtask

  task automatic wait_pc(input string name, input logic [XLEN-1:0] target, input int limit);
    int n;
    n = 0;
    tick();
    while (!(valid_id && pc_id == target) && n < limit) begin
      tick();
      n++;
    end
    if (!(valid_id && pc_id == target)) begin
      timeout_errors++;
      $display("%s: address %h was never fetched within %0d cycles", name, target, limit);
    end
  endtask

  // Decode sees each instruction with the word stored at its own address
  always @(negedge clk) begin
    if (rst_n && valid_id) begin
      check_value("content_instr", mirror[pc_id[IMEM_AW+1:2]], instr_id);
      check_value("content_pc_plus4", pc_id + 32'd4, pc_plus4_id);
    end
  end

  task automatic reset_and_load();
    logic [IMEM_AW-1:0] w;
    // The load keeps the core in reset, then reset stays low for 10 more cycles
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      w = IMEM_AW'(i);
      // Every eighth word is a marker built from its whole address
      if (w[2:0] == 3'd0) begin
        mirror[i] = {~w, w, 16'h0013};
      end else begin
        mirror[i] = $urandom;
      end
      load_en   = 1'b1;
      load_addr = w;
      load_data = mirror[i];
      tick();
      check_value("reset_flags", 32'd0, {27'd0, valid_id, btb_hit_id, btb_taken_id,
                                         btb_is_return_id, ras_valid_id});
    end
    load_en = 1'b0;
    for (int i = 0; i < 10; i++) begin
      tick();
      check_value("reset_flags", 32'd0, {27'd0, valid_id, btb_hit_id, btb_taken_id,
                                         btb_is_return_id, ras_valid_id});
    end
    rst_n = 1'b1;
    tick();
    // The first edge after reset only primes the RAM output
    check_value("first_edge_valid", 32'd0, {31'd0, valid_id});
    wait_valid("reset_start", 4);
    check_value("reset_start_pc", RESET_PC, pc_id);
  endtask

  // Starts on a valid slot, untrained code steps by one word
  task automatic run_sequential(input string name, input int count);
    logic [XLEN-1:0] prev;
    prev = pc_id;
    for (int i = 0; i < count; i++) begin
      wait_valid(name, 8);
      check_value(name, prev + 32'd4, pc_id);
      prev = pc_id;
    end
  endtask

  task automatic stall_once(input string name);
    logic [164:0]    snap;
    logic [XLEN-1:0] prev_pc;
    int              len;
    len     = 2 + int'($urandom % 9);
    snap    = outputs_now();
    prev_pc = pc_id;
    id_ready = 1'b0;
    for (int i = 0; i < len; i++) begin
      tick();
      assert (outputs_now() === snap) else begin
        value_errors++;
        $display("ERR %s expected %h actual %h", name, snap, outputs_now());
      end
    end
    id_ready = 1'b1;
    wait_valid(name, 8);
    check_value({name, "_resume_pc"}, prev_pc + 32'd4, pc_id);
  endtask

  // Squashed slots count until the target shows up as the next valid slot
  task automatic redirect_to(input string name, input logic [XLEN-1:0] target);
    int squashed;
    squashed       = 0;
    redirect_valid = 1'b1;
    redirect_pc    = target;
    tick();
    redirect_valid = 1'b0;
    while (!valid_id && squashed < 8) begin
      check_value({name, "_nop"}, I_NOP, instr_id);
      squashed++;
      tick();
    end
    if (!valid_id) begin
      timeout_errors++;
      $display("%s: fetch did not resume after the redirect", name);
    end
    // Without early fetch one stale sequential word is squashed as well
    check_value({name, "_squashed"}, (BPRED != 0) ? 32'd1 : 32'd2, squashed);
    check_value({name, "_pc"}, target, pc_id);
  endtask

  task automatic train(input logic [XLEN-1:0] site, input logic [XLEN-1:0] target,
                       input logic call, input logic ret);
    upd_valid     = 1'b1;
    upd_pc        = site;
    upd_target    = target;
    upd_taken     = 1'b1;
    upd_is_call   = call;
    upd_is_return = ret;
    tick();
    upd_valid = 1'b0;
  endtask

  task automatic branch_test();
    logic [XLEN-1:0] br_pc;
    logic [XLEN-1:0] br_target;
    br_pc     = 32'h0000_0100;
    br_target = 32'h0000_0200;
    train(br_pc, br_target, 1'b0, 1'b0);
    redirect_to("branch_redirect", br_pc - 32'd8);
    wait_pc("branch_fetch", br_pc, 16);
    check_value("branch_hit", 32'd1, {31'd0, btb_hit_id});
    check_value("branch_taken", 32'd1, {31'd0, btb_taken_id});
    check_value("branch_target_id", br_target, btb_target_id);
    wait_valid("branch_next", 8);
    check_value("branch_next_pc", br_target, pc_id);
  endtask

  // Call at 0x144 into a function whose return sits two words in
  task automatic call_return_test();
    logic [XLEN-1:0] call_pc;
    logic [XLEN-1:0] func_pc;
    logic [XLEN-1:0] ret_pc;
    call_pc = 32'h0000_0144;
    func_pc = 32'h0000_0300;
    ret_pc  = 32'h0000_0308;
    train(call_pc, func_pc, 1'b1, 1'b0);
    train(ret_pc, 32'd0, 1'b0, 1'b1);
    redirect_to("call_redirect", call_pc - 32'd4);
    wait_pc("call_fetch", call_pc, 16);
    wait_valid("call_next", 8);
    check_value("call_next_pc", func_pc, pc_id);
    wait_pc("return_fetch", ret_pc, 16);
    check_value("return_ras_valid", 32'd1, {31'd0, ras_valid_id});
    check_value("return_is_return", 32'd1, {31'd0, btb_is_return_id});
    check_value("return_ras_target", call_pc + 32'd4, ras_target_id);
    wait_valid("return_next", 8);
    check_value("return_next_pc", call_pc + 32'd4, pc_id);
  endtask

  initial begin
    void'($urandom(32'hc87d));
    clk            = 1'b0;
    rst_n          = 1'b0;
    id_ready       = 1'b1;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    upd_valid      = 1'b0;
    upd_pc         = '0;
    upd_target     = '0;
    upd_taken      = 1'b0;
    upd_is_call    = 1'b0;
    upd_is_return  = 1'b0;
    load_en        = 1'b0;
    load_addr      = '0;
    load_data      = '0;
    value_errors   = 0;
    timeout_errors = 0;

    reset_and_load();
    run_sequential("sequential", 40);
    for (int i = 0; i < 4; i++) begin
      stall_once("backpressure");
      run_sequential("after_stall", 5);
    end
    for (int i = 0; i < 3; i++) begin
      redirect_to("redirect", {22'd0, 8'($urandom), 2'b00});
      run_sequential("after_redirect", 6);
    end
    if (BPRED != 0) begin
      branch_test();
      call_return_test();
    end
    tick();

    $display("errors: value=%0d timeout=%0d", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
